//--- dv/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/decode_stage_properties.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_properties (
    input wire        clk,
    input wire        reset,
    input wire        ds_valid,
    input wire        es_valid,
    input wire        es_allowin,
    input wire        load_use_stall,
    input wire [31:0] es_pc,
    input wire [11:0] es_alu_op,
    input wire [31:0] es_alu_src1,
    input wire [31:0] es_alu_src2,
    input wire [31:0] es_rkd_value,
    input wire [4:0]  es_dest
);

    valid_low_after_reset: assert property (@(posedge clk) reset |=> !es_valid)
        else $error("es_valid high right after reset");

    // a stalled instruction keeps its slot in decode
    stall_holds_slot: assert property (@(posedge clk) disable iff (reset)
        ds_valid && load_use_stall |=> ds_valid && $stable(es_pc))
        else $error("stalled instruction left decode");

    // held payload must not move until execute takes it
    payload_held: assert property (@(posedge clk) disable iff (reset)
        es_valid && !es_allowin |=> es_valid && $stable(es_pc) && $stable(es_alu_op)
            && $stable(es_alu_src1) && $stable(es_alu_src2)
            && $stable(es_rkd_value) && $stable(es_dest))
        else $error("payload changed under back-pressure");

endmodule

`default_nettype wire

//--- dv/decode_tests.txt
# name ra va rb vb inst pc es_d es_v ms_d ms_v ws_d ws_v load stall hold
#   alu_op src1 src2 rkd dest flags(ld,st,we) br(0 no,1 taken,2 not a branch) target
add_w 1 11111111 2 22222222 00100823 1c000000 0 0 0 0 0 0 0 0 0 001 11111111 22222222 22222222 3 1 2 0
sub_w 5 50 6 60 001118a4 1c000100 0 0 0 0 0 0 0 0 0 002 50 60 60 4 1 2 0
slt 1 fffffff0 2 5 00120827 1c000200 0 0 0 0 0 0 0 0 0 004 fffffff0 5 5 7 1 2 0
nor 1 0f0f0f0f 2 00ff00ff 00140828 1c000300 0 0 0 0 0 0 0 0 0 020 0f0f0f0f 00ff00ff 00ff00ff 8 1 2 0
addi_w 1 100 1f 0 02bffc29 1c000400 0 0 0 0 0 0 0 0 0 001 100 ffffffff 0 9 1 2 0
slli_w 1 3 5 77 0040942a 1c000500 0 0 0 0 0 0 0 0 0 100 3 5 77 a 1 2 0
lu12i_w 5 55 1a 26 142468ab 1c000600 0 0 0 0 0 0 0 0 0 800 55 12345000 26 b 1 2 0
ld_w 1 1000 8 88 2880202c 1c000700 0 0 0 0 0 0 0 0 0 001 1000 8 88 c 5 2 0
st_w 1 2000 2 abcd 29801022 1c000800 0 0 0 0 0 0 0 0 0 001 2000 4 abcd 2 2 2 0
r0_zero 0 deadbeef 2 12121212 00100803 1c000900 0 0 0 0 0 0 0 0 0 001 0 12121212 12121212 3 1 2 0
undefined 1 1 2 2 ffffffff 1c000a00 0 0 0 0 0 0 0 0 0 000 0 0 0 1f 0 2 0
fwd_es_first 1 1 2 2 00100823 1c000b00 1 e1 1 b1 2 c2 0 0 0 001 e1 c2 c2 3 1 2 0
fwd_zero_dest 1 1 2 2 00100803 1c000c00 0 ee 2 b2 2 c2 0 0 0 001 0 b2 b2 3 1 2 0
load_use 1 1 2 2 00100823 1c000d00 2 2222aaaa 0 0 0 0 1 3 0 001 1 2222aaaa 2222aaaa 3 1 2 0
back_pressure 5 5 6 6 001118a4 1c000e00 0 0 0 0 0 0 0 0 4 002 5 6 6 4 1 2 0
beq_taken 1 7 2 7 58001022 1c000f00 0 0 0 0 0 0 0 0 0 000 7 7 7 2 0 1 1c000f10
beq_not 1 7 2 8 58001022 1c001000 0 0 0 0 0 0 0 0 0 000 7 8 8 2 0 0 1c001010
bne_taken 1 7 2 8 5c001022 1c001100 0 0 0 0 0 0 0 0 0 000 7 8 8 2 0 1 1c001110
bne_not 1 9 2 9 5c001022 1c001200 0 0 0 0 0 0 0 0 0 000 9 9 9 2 0 0 1c001210
bl 1 1 2 2 54004000 1c001300 0 0 0 0 0 0 0 0 0 001 1c001300 4 0 1 1 1 1c001340
jirl 5 1c003000 2 2 4c0008a1 1c001400 0 0 0 0 0 0 0 0 0 001 1c001400 4 2 1 1 1 1c003008

//--- dv/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

    logic        clk, reset;
    logic        fs_valid, ds_allowin, es_allowin, es_valid;
    logic [31:0] fs_inst, fs_pc, es_pc, es_alu_src1, es_alu_src2, es_rkd_value;
    logic [11:0] es_alu_op;
    logic        es_res_from_mem, es_mem_we, es_gr_we, br_taken;
    logic [4:0]  es_dest, es_dest_in, ms_dest_in, ws_dest_in, ws_rf_waddr;
    logic [31:0] br_target, es_value_in, ms_value_in, ws_value_in, ws_rf_wdata;
    logic        es_value_from_mem, ws_rf_we;
    logic [147:0] payload;

    string       name, line;
    logic [31:0] ra, va, rb, vb, inst, pc, ed, ev, md, mv, wd, wv;
    logic [31:0] load, stall, hold, x_op, x_src1, x_src2, x_rkd, x_dest, x_flags;
    logic [31:0] x_br, x_target;
    int          test_errs, passed, failed;
    bit          aborted;

    clock_gen u_clock_gen (.clk(clk), .reset(reset));

    decode_stage i_decode_stage (.*);

    bind decode_stage decode_stage_properties u_properties (
        .clk(clk), .reset(reset), .ds_valid(ds_valid), .es_valid(es_valid),
        .es_allowin(es_allowin), .load_use_stall(load_use_stall), .es_pc(es_pc),
        .es_alu_op(es_alu_op), .es_alu_src1(es_alu_src1), .es_alu_src2(es_alu_src2),
        .es_rkd_value(es_rkd_value), .es_dest(es_dest)
    );

    assign payload = {es_pc, es_alu_op, es_alu_src1, es_alu_src2, es_rkd_value,
                      es_dest, es_res_from_mem, es_mem_we, es_gr_we};

    task automatic abort_run(input string why);
        $display("ERROR: %s in test %s", why, name);
        aborted = 1'b1;
    endtask

    task automatic check_val(input string sig, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, sig, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok === 1'b1) else begin
            $display("ERROR time=%0t test %s: %s", $time, name, what);
            test_errs++;
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        ws_rf_we    = 1'b1;
        ws_rf_waddr = addr;
        ws_rf_wdata = data;
    endtask

    task automatic wait_for_reset_release();
        int cnt;
        cnt = 0;
        while (reset !== 1'b0 && cnt < 50) begin
            @(negedge clk);
            cnt++;
        end
        if (reset !== 1'b0) abort_run("timeout waiting for reset release");
    endtask

    task automatic wait_for_allowin();
        int cnt;
        cnt = 0;
        while (!ds_allowin && cnt < 50) begin
            @(negedge clk);
            cnt++;
        end
        if (!ds_allowin) abort_run("timeout waiting for ds_allowin");
    endtask

    task automatic wait_for_es_valid();
        int cnt;
        cnt = 0;
        #1;
        while (!es_valid && cnt < 50) begin
            @(negedge clk);
            #1;
            cnt++;
        end
        if (!es_valid) abort_run("timeout waiting for es_valid");
    endtask

    task automatic run_one_test();
        logic [147:0] held;
        test_errs = 0;
        write_reg(ra[4:0], va);
        write_reg(rb[4:0], vb);
        @(negedge clk);
        ws_rf_we = 1'b0;
        wait_for_allowin();
        if (aborted) return;
        es_dest_in        = ed[4:0];
        es_value_in       = ev;
        ms_dest_in        = md[4:0];
        ms_value_in       = mv;
        ws_dest_in        = wd[4:0];
        ws_value_in       = wv;
        fs_valid          = 1'b1;
        fs_inst           = inst;
        fs_pc             = pc;
        es_value_from_mem = load[0];
        es_allowin        = (hold == 0);
        @(negedge clk);
        // a marker behind a taken branch must be dropped
        fs_valid = (x_br == 1);
        fs_inst  = 32'h00100823;
        fs_pc    = 32'hdead0000;
        for (int i = 0; i < stall; i++) begin
            #1;
            check_true(!es_valid, "es_valid high during load-use stall");
            check_true(!ds_allowin, "ds_allowin high during load-use stall");
            @(negedge clk);
        end
        es_value_from_mem = 1'b0;
        wait_for_es_valid();
        if (aborted) return;
        held = payload;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            #1;
            check_true(es_valid, "es_valid dropped under back-pressure");
            check_true(!ds_allowin, "ds_allowin high under back-pressure");
            check_true(payload === held, "payload changed under back-pressure");
        end
        if (hold != 0) begin
            @(negedge clk);
            es_allowin = 1'b1;
        end
        #1;
        check_val("es_alu_op", {20'b0, es_alu_op}, x_op);
        check_val("es_alu_src1", es_alu_src1, x_src1);
        check_val("es_alu_src2", es_alu_src2, x_src2);
        check_val("es_rkd_value", es_rkd_value, x_rkd);
        check_val("es_dest", {27'b0, es_dest}, x_dest);
        check_val("es_flags", {29'b0, es_res_from_mem, es_mem_we, es_gr_we}, x_flags);
        check_val("es_pc", es_pc, pc);
        check_val("br_taken", {31'b0, br_taken}, (x_br == 1));
        if (x_br != 2) begin
            check_val("br_target", br_target, x_target);
        end
        @(negedge clk);
        fs_valid   = 1'b0;
        es_dest_in = '0;
        ms_dest_in = '0;
        ws_dest_in = '0;
        #1;
        check_true(!es_valid, "instruction after transfer still valid in decode");
        if (test_errs == 0) begin
            $display("test %s: ok", name);
            passed++;
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            failed++;
        end
    endtask

    task automatic run_test_file();
        int fd;
        int n;
        fd = $fopen("dv/decode_tests.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open dv/decode_tests.txt");
            return;
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line,
                    "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, ra, va, rb, vb, inst, pc, ed, ev, md, mv, wd, wv,
                    load, stall, hold, x_op, x_src1, x_src2, x_rkd, x_dest,
                    x_flags, x_br, x_target);
                if (n != 24) begin
                    abort_run("malformed line in test file");
                end else begin
                    run_one_test();
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        fs_valid = 0;
        fs_inst = '0;
        fs_pc = '0;
        es_allowin = 1;
        es_dest_in = '0;
        ms_dest_in = '0;
        ws_dest_in = '0;
        es_value_in = '0;
        ms_value_in = '0;
        ws_value_in = '0;
        es_value_from_mem = 0;
        ws_rf_we = 0;
        ws_rf_waddr = '0;
        ws_rf_wdata = '0;
        passed = 0;
        failed = 0;
        aborted = 1'b0;
        name = "setup";
        wait_for_reset_release();
        if (!aborted) begin
            for (int r = 1; r < 32; r++) begin
                write_reg(r[4:0], 32'h0);
            end
            run_test_file();
        end
        $display("tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
        if (!aborted && failed == 0 && passed > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -f sources.f \
    --top-module tb_decode_stage -o sim_decode_stage

out=$(./obj_dir/sim_decode_stage)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1

//--- sources.f
src/la_decode_pkg.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_forward.sv
src/branch_unit.sv
src/decode_stage.sv
dv/clock_gen.sv
dv/decode_stage_properties.sv
dv/tb_decode_stage.sv

//--- src/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  logic                           ds_valid,
    input  logic                           is_beq,
    input  logic                           is_bne,
    input  logic                           is_jump,
    input  logic                           is_jirl,
    input  logic [la_decode_pkg::xlen-1:0] rj_value,
    input  logic [la_decode_pkg::xlen-1:0] rkd_value,
    input  logic [la_decode_pkg::xlen-1:0] pc,
    input  logic [la_decode_pkg::xlen-1:0] br_offs,
    input  logic [la_decode_pkg::xlen-1:0] jirl_offs,
    output logic                           br_taken,
    output logic [la_decode_pkg::xlen-1:0] br_target
);

    logic rj_eq_rd;
    logic cond_taken;

    assign rj_eq_rd = rj_value == rkd_value;

    // b, bl and jirl are always taken
    assign cond_taken = (is_beq && rj_eq_rd)
                     || (is_bne && !rj_eq_rd)
                     || is_jump;

    assign br_taken = ds_valid && cond_taken;

    // jirl is register relative, everything else pc relative
    assign br_target = is_jirl ? rj_value + jirl_offs : pc + br_offs;

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 fs_valid,
    input  logic [la_decode_pkg::xlen-1:0]       fs_inst,
    input  logic [la_decode_pkg::xlen-1:0]       fs_pc,
    output logic                                 ds_allowin,
    input  logic                                 es_allowin,
    output logic                                 es_valid,
    output logic [la_decode_pkg::xlen-1:0]       es_pc,
    output logic [la_decode_pkg::alu_op_w-1:0]   es_alu_op,
    output logic [la_decode_pkg::xlen-1:0]       es_alu_src1,
    output logic [la_decode_pkg::xlen-1:0]       es_alu_src2,
    output logic [la_decode_pkg::xlen-1:0]       es_rkd_value,
    output logic                                 es_res_from_mem,
    output logic                                 es_mem_we,
    output logic                                 es_gr_we,
    output logic [la_decode_pkg::reg_addr_w-1:0] es_dest,
    output logic                                 br_taken,
    output logic [la_decode_pkg::xlen-1:0]       br_target,
    input  logic [la_decode_pkg::reg_addr_w-1:0] es_dest_in,
    input  logic [la_decode_pkg::reg_addr_w-1:0] ms_dest_in,
    input  logic [la_decode_pkg::reg_addr_w-1:0] ws_dest_in,
    input  logic [la_decode_pkg::xlen-1:0]       es_value_in,
    input  logic [la_decode_pkg::xlen-1:0]       ms_value_in,
    input  logic [la_decode_pkg::xlen-1:0]       ws_value_in,
    input  logic                                 es_value_from_mem,
    input  logic                                 ws_rf_we,
    input  logic [la_decode_pkg::reg_addr_w-1:0] ws_rf_waddr,
    input  logic [la_decode_pkg::xlen-1:0]       ws_rf_wdata
);

    logic                                 ds_valid;
    logic [la_decode_pkg::xlen-1:0]       ds_inst;
    logic [la_decode_pkg::xlen-1:0]       ds_pc;
    logic                                 ready_go;
    logic                                 br_kill;
    logic [la_decode_pkg::reg_addr_w-1:0] rf_raddr1, rf_raddr2;
    logic [la_decode_pkg::xlen-1:0]       rf_rdata1, rf_rdata2;
    logic [la_decode_pkg::xlen-1:0]       rj_value, rkd_value;
    logic [la_decode_pkg::xlen-1:0]       imm, br_offs, jirl_offs;
    logic                                 reads_rj, reads_r2, load_use_stall;
    logic                                 src1_is_pc, src2_is_imm;
    logic                                 is_beq, is_bne, is_jump, is_jirl;

    assign ready_go   = !load_use_stall;
    assign ds_allowin = !ds_valid || (ready_go && es_allowin);
    assign es_valid   = ds_valid && ready_go;
    // taken branch drops the slot behind it as it leaves
    assign br_kill    = br_taken && ready_go && es_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (br_kill) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    inst_decoder u_inst_decoder (
        .inst         (ds_inst),
        .rf_raddr1    (rf_raddr1),
        .rf_raddr2    (rf_raddr2),
        .dest         (es_dest),
        .reads_rj     (reads_rj),
        .reads_r2     (reads_r2),
        .imm          (imm),
        .br_offs      (br_offs),
        .jirl_offs    (jirl_offs),
        .alu_op       (es_alu_op),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .res_from_mem (es_res_from_mem),
        .mem_we       (es_mem_we),
        .gr_we        (es_gr_we),
        .is_beq       (is_beq),
        .is_bne       (is_bne),
        .is_jump      (is_jump),
        .is_jirl      (is_jirl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (ws_rf_we),
        .waddr  (ws_rf_waddr),
        .wdata  (ws_rf_wdata)
    );

    operand_forward u_operand_forward (
        .raddr1            (rf_raddr1),
        .raddr2            (rf_raddr2),
        .reads_rj          (reads_rj),
        .reads_r2          (reads_r2),
        .rdata1            (rf_rdata1),
        .rdata2            (rf_rdata2),
        .es_dest           (es_dest_in),
        .es_value          (es_value_in),
        .ms_dest           (ms_dest_in),
        .ms_value          (ms_value_in),
        .ws_dest           (ws_dest_in),
        .ws_value          (ws_value_in),
        .es_value_from_mem (es_value_from_mem),
        .rj_value          (rj_value),
        .rkd_value         (rkd_value),
        .load_use_stall    (load_use_stall)
    );

    branch_unit u_branch_unit (
        .ds_valid  (ds_valid),
        .is_beq    (is_beq),
        .is_bne    (is_bne),
        .is_jump   (is_jump),
        .is_jirl   (is_jirl),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .pc        (ds_pc),
        .br_offs   (br_offs),
        .jirl_offs (jirl_offs),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    // operands to execute
    assign es_pc        = ds_pc;
    assign es_alu_src1  = src1_is_pc ? ds_pc : rj_value;
    assign es_alu_src2  = src2_is_imm ? imm : rkd_value;
    assign es_rkd_value = rkd_value;

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  logic [la_decode_pkg::xlen-1:0]       inst,
    output logic [la_decode_pkg::reg_addr_w-1:0] rf_raddr1,
    output logic [la_decode_pkg::reg_addr_w-1:0] rf_raddr2,
    output logic [la_decode_pkg::reg_addr_w-1:0] dest,
    output logic                                 reads_rj,
    output logic                                 reads_r2,
    output logic [la_decode_pkg::xlen-1:0]       imm,
    output logic [la_decode_pkg::xlen-1:0]       br_offs,
    output logic [la_decode_pkg::xlen-1:0]       jirl_offs,
    output logic [la_decode_pkg::alu_op_w-1:0]   alu_op,
    output logic                                 src1_is_pc,
    output logic                                 src2_is_imm,
    output logic                                 res_from_mem,
    output logic                                 mem_we,
    output logic                                 gr_we,
    output logic                                 is_beq,
    output logic                                 is_bne,
    output logic                                 is_jump,
    output logic                                 is_jirl
);

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;
    logic [4:0]  rd, rj, rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w, inst_lu12i_w;
    logic inst_ld_w, inst_st_w, inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic rr_any, shift_imm, known, src2_is_4;
    logic [la_decode_pkg::xlen-1:0] offs16;

    assign op17 = inst[31:15];
    assign op10 = inst[31:22];
    assign op7  = inst[31:25];
    assign op6  = inst[31:26];
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];
    assign i12  = inst[21:10];
    assign i20  = inst[24:5];
    assign i16  = inst[25:10];
    assign i26  = {inst[9:0], inst[25:10]};

    assign inst_add_w   = op17 == la_decode_pkg::op17_add_w;
    assign inst_sub_w   = op17 == la_decode_pkg::op17_sub_w;
    assign inst_slt     = op17 == la_decode_pkg::op17_slt;
    assign inst_sltu    = op17 == la_decode_pkg::op17_sltu;
    assign inst_nor     = op17 == la_decode_pkg::op17_nor;
    assign inst_and     = op17 == la_decode_pkg::op17_and;
    assign inst_or      = op17 == la_decode_pkg::op17_or;
    assign inst_xor     = op17 == la_decode_pkg::op17_xor;
    assign inst_slli_w  = op17 == la_decode_pkg::op17_slli_w;
    assign inst_srli_w  = op17 == la_decode_pkg::op17_srli_w;
    assign inst_srai_w  = op17 == la_decode_pkg::op17_srai_w;
    assign inst_addi_w  = op10 == la_decode_pkg::op10_addi_w;
    assign inst_ld_w    = op10 == la_decode_pkg::op10_ld_w;
    assign inst_st_w    = op10 == la_decode_pkg::op10_st_w;
    assign inst_lu12i_w = op7 == la_decode_pkg::op7_lu12i_w;
    assign inst_jirl    = op6 == la_decode_pkg::op6_jirl;
    assign inst_b       = op6 == la_decode_pkg::op6_b;
    assign inst_bl      = op6 == la_decode_pkg::op6_bl;
    assign inst_beq     = op6 == la_decode_pkg::op6_beq;
    assign inst_bne     = op6 == la_decode_pkg::op6_bne;

    assign rr_any    = inst_add_w | inst_sub_w | inst_slt | inst_sltu
                     | inst_nor | inst_and | inst_or | inst_xor;
    assign shift_imm = inst_slli_w | inst_srli_w | inst_srai_w;
    assign known     = rr_any | shift_imm | inst_addi_w | inst_lu12i_w | inst_ld_w
                     | inst_st_w | inst_jirl | inst_b | inst_bl | inst_beq | inst_bne;

    always_comb begin
        alu_op = '0;
        alu_op[la_decode_pkg::alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                                        | inst_jirl | inst_bl;
        alu_op[la_decode_pkg::alu_sub]  = inst_sub_w;
        alu_op[la_decode_pkg::alu_slt]  = inst_slt;
        alu_op[la_decode_pkg::alu_sltu] = inst_sltu;
        alu_op[la_decode_pkg::alu_and]  = inst_and;
        alu_op[la_decode_pkg::alu_nor]  = inst_nor;
        alu_op[la_decode_pkg::alu_or]   = inst_or;
        alu_op[la_decode_pkg::alu_xor]  = inst_xor;
        alu_op[la_decode_pkg::alu_sll]  = inst_slli_w;
        alu_op[la_decode_pkg::alu_srl]  = inst_srli_w;
        alu_op[la_decode_pkg::alu_sra]  = inst_srai_w;
        alu_op[la_decode_pkg::alu_lui]  = inst_lu12i_w;
    end

    // link address is pc + 4 through the adder
    assign src2_is_4 = inst_jirl | inst_bl;
    assign imm = src2_is_4    ? la_decode_pkg::link_offset :
                 inst_lu12i_w ? {i20, 12'b0} :
                 shift_imm    ? {27'b0, rk} :
                                {{20{i12[11]}}, i12};

    assign offs16    = {{14{i16[15]}}, i16, 2'b0};
    assign br_offs   = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0} : offs16;
    assign jirl_offs = offs16;

    // branches and stores read rd as the second source
    assign rf_raddr1 = rj;
    assign rf_raddr2 = (inst_beq | inst_bne | inst_st_w) ? rd : rk;
    assign dest      = inst_bl ? la_decode_pkg::link_reg : rd;

    assign reads_rj = rr_any | shift_imm | inst_addi_w | inst_ld_w | inst_st_w
                    | inst_beq | inst_bne | inst_jirl;
    assign reads_r2 = rr_any | inst_st_w | inst_beq | inst_bne;

    assign src1_is_pc   = inst_jirl | inst_bl;
    assign src2_is_imm  = shift_imm | inst_addi_w | inst_lu12i_w | inst_ld_w | inst_st_w
                        | src2_is_4;
    assign res_from_mem = inst_ld_w;
    assign mem_we       = inst_st_w;
    // unknown encodings write nothing
    assign gr_we        = known & ~(inst_st_w | inst_beq | inst_bne | inst_b);
    assign is_beq       = inst_beq;
    assign is_bne       = inst_bne;
    assign is_jump      = inst_b | inst_bl | inst_jirl;
    assign is_jirl      = inst_jirl;

endmodule

`default_nettype wire

//--- src/la_decode_pkg.sv
`default_nettype none

package la_decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 12;

    // one-hot alu operation positions
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    localparam logic [reg_addr_w-1:0] link_reg    = 5'd1;
    localparam logic [xlen-1:0]       link_offset = 32'd4;

    // 3R and shift-imm ops, matched on inst[31:15]
    localparam logic [16:0] op17_add_w  = 17'h00020;
    localparam logic [16:0] op17_sub_w  = 17'h00022;
    localparam logic [16:0] op17_slt    = 17'h00024;
    localparam logic [16:0] op17_sltu   = 17'h00025;
    localparam logic [16:0] op17_nor    = 17'h00028;
    localparam logic [16:0] op17_and    = 17'h00029;
    localparam logic [16:0] op17_or     = 17'h0002a;
    localparam logic [16:0] op17_xor    = 17'h0002b;
    localparam logic [16:0] op17_slli_w = 17'h00081;
    localparam logic [16:0] op17_srli_w = 17'h00089;
    localparam logic [16:0] op17_srai_w = 17'h00091;

    // si12 forms, matched on inst[31:22]
    localparam logic [9:0] op10_addi_w = 10'h00a;
    localparam logic [9:0] op10_ld_w   = 10'h0a2;
    localparam logic [9:0] op10_st_w   = 10'h0a6;

    localparam logic [6:0] op7_lu12i_w = 7'h0a;

    localparam logic [5:0] op6_jirl = 6'h13;
    localparam logic [5:0] op6_b    = 6'h14;
    localparam logic [5:0] op6_bl   = 6'h15;
    localparam logic [5:0] op6_beq  = 6'h16;
    localparam logic [5:0] op6_bne  = 6'h17;

endpackage

`default_nettype wire

//--- src/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  logic [la_decode_pkg::reg_addr_w-1:0] raddr1,
    input  logic [la_decode_pkg::reg_addr_w-1:0] raddr2,
    input  logic                                 reads_rj,
    input  logic                                 reads_r2,
    input  logic [la_decode_pkg::xlen-1:0]       rdata1,
    input  logic [la_decode_pkg::xlen-1:0]       rdata2,
    input  logic [la_decode_pkg::reg_addr_w-1:0] es_dest,
    input  logic [la_decode_pkg::xlen-1:0]       es_value,
    input  logic [la_decode_pkg::reg_addr_w-1:0] ms_dest,
    input  logic [la_decode_pkg::xlen-1:0]       ms_value,
    input  logic [la_decode_pkg::reg_addr_w-1:0] ws_dest,
    input  logic [la_decode_pkg::xlen-1:0]       ws_value,
    input  logic                                 es_value_from_mem,
    output logic [la_decode_pkg::xlen-1:0]       rj_value,
    output logic [la_decode_pkg::xlen-1:0]       rkd_value,
    output logic                                 load_use_stall
);

    logic es_hit1, es_hit2;

    // youngest producer wins, r0 never forwards
    function automatic logic [la_decode_pkg::xlen-1:0] pick(
        input logic [la_decode_pkg::reg_addr_w-1:0] addr,
        input logic [la_decode_pkg::xlen-1:0]       rf_value
    );
        logic [la_decode_pkg::xlen-1:0] result;
        begin
            if (addr == '0) begin
                result = rf_value;
            end else if (addr == es_dest) begin
                result = es_value;
            end else if (addr == ms_dest) begin
                result = ms_value;
            end else if (addr == ws_dest) begin
                result = ws_value;
            end else begin
                result = rf_value;
            end
            return result;
        end
    endfunction

    always_comb begin
        rj_value  = pick(raddr1, rdata1);
        rkd_value = pick(raddr2, rdata2);
    end

    assign es_hit1 = reads_rj && raddr1 != '0 && raddr1 == es_dest;
    assign es_hit2 = reads_r2 && raddr2 != '0 && raddr2 == es_dest;

    // load data is not ready until memory stage
    assign load_use_stall = es_value_from_mem && (es_hit1 || es_hit2);

endmodule

`default_nettype wire

//--- src/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                                 clk,
    input  logic [la_decode_pkg::reg_addr_w-1:0] raddr1,
    input  logic [la_decode_pkg::reg_addr_w-1:0] raddr2,
    output logic [la_decode_pkg::xlen-1:0]       rdata1,
    output logic [la_decode_pkg::xlen-1:0]       rdata2,
    input  logic                                 we,
    input  logic [la_decode_pkg::reg_addr_w-1:0] waddr,
    input  logic [la_decode_pkg::xlen-1:0]       wdata
);

    logic [la_decode_pkg::xlen-1:0] rf [2**la_decode_pkg::reg_addr_w];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    // same-cycle write is not bypassed here
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire
